// File: Makefile
TOP = tb_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f verilog.f -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Test failed" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_top;

	////////////////////
	// Run length
	localparam int CLK_HALF_NS  = 4;
	localparam int RESET_CYCLES = 5;
	localparam int SENSOR_BEATS = 200;
	localparam int PIN_BEATS    = 32;
	localparam int PAT_FRAMES   = 9;
	localparam int PWM_WINDOWS  = 5;
	localparam int PWM_PERIOD   = 1 << cam_bridge_pkg::PWM_CNT_W;
	localparam int PWM_STEP     = 1 << (cam_bridge_pkg::PWM_CNT_W - cam_bridge_pkg::PWM_DUTY_W);
	localparam int FRAME_CYCLES = cam_bridge_pkg::PAT_H_TOTAL * cam_bridge_pkg::PAT_V_TOTAL;
	// Sum of all test lengths plus slack for writes and resets
	localparam int TEST_CYCLES  = SENSOR_BEATS + (PAT_FRAMES + 1) * FRAME_CYCLES +
		PWM_WINDOWS * (PWM_PERIOD + 16) + 2 * PIN_BEATS + 200;
	localparam longint WATCHDOG_NS = 2 * TEST_CYCLES * 2 * CLK_HALF_NS;

	logic w_csi_rx_clk;
	logic w_sys_rstn;

	// Command bus
	logic        dev_wr;
	logic [cam_bridge_pkg::DEV_IDX_W-1:0]  dev_index;
	logic [cam_bridge_pkg::DEV_CMD_W-1:0]  dev_cmd;
	logic [cam_bridge_pkg::DEV_DATA_W-1:0] dev_wdata;

	// Sensor side
	logic sen_fv;
	logic sen_lv;
	logic sen_de;
	cam_bridge_pkg::pixel_t sen_data;

	// Master side of the shared pins
	logic       spi_ssn;
	logic       spi_sck;
	logic [3:0] spi_dat_out;
	logic [3:0] spi_dat_oe;
	logic       i2c_scl;
	logic       i2c_sda;
	logic       i2c_sda_oe;
	logic       pin_d1;

	// DUT outputs
	logic vid_fv;
	logic vid_lv;
	cam_bridge_pkg::pixel_t vid_data;
	logic pix_rstn;
	logic led;
	logic pwm;
	logic pin_cs;
	logic pin_sck;
	logic pin_sck_oe;
	logic [3:0] pin_dat;
	logic [3:0] pin_dat_oe;
	logic i2c_sda_in;

	int errors;
	int tests_run;

	cam_bridge_top dut0 (
		.w_csi_rx_clk_i (w_csi_rx_clk),
		.w_sys_rstn_i   (w_sys_rstn),
		.dev_wr_i       (dev_wr),
		.dev_index_i    (dev_index),
		.dev_cmd_i      (dev_cmd),
		.dev_wdata_i    (dev_wdata),
		.sen_fv_i       (sen_fv),
		.sen_lv_i       (sen_lv),
		.sen_de_i       (sen_de),
		.sen_data_i     (sen_data),
		.spi_ssn_i      (spi_ssn),
		.spi_sck_i      (spi_sck),
		.spi_dat_o_i    (spi_dat_out),
		.spi_dat_oe_i   (spi_dat_oe),
		.i2c_scl_i      (i2c_scl),
		.i2c_sda_i      (i2c_sda),
		.i2c_sda_oe_i   (i2c_sda_oe),
		.pin_d1_i       (pin_d1),
		.vid_fv_o       (vid_fv),
		.vid_lv_o       (vid_lv),
		.vid_data_o     (vid_data),
		.pix_rstn_o     (pix_rstn),
		.led_o          (led),
		.pwm_o          (pwm),
		.spi_cs_o       (pin_cs),
		.spi_sck_o      (pin_sck),
		.spi_sck_oe_o   (pin_sck_oe),
		.pin_dat_o      (pin_dat),
		.pin_dat_oe_o   (pin_dat_oe),
		.i2c_sda_in_o   (i2c_sda_in)
	);

	initial begin
		w_csi_rx_clk = 1'b0;
		forever #(CLK_HALF_NS) w_csi_rx_clk = ~w_csi_rx_clk;
	end

	// Hard stop if a test never finishes
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run still busy after %0d ns", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	////////////////////
	// Reporting
	task automatic report_mismatch(input string sig, input logic [63:0] got,
		input logic [63:0] exp);
		errors++;
		$display("mismatch %s: got 0x%0h expected 0x%0h at %0t", sig, got, exp, $time);
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("error: %s at %0t", msg, $time);
	endtask

	task automatic end_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - err_start);
	endtask

	////////////////////
	// Bus and reset helpers
	task automatic apply_reset();
		@(posedge w_csi_rx_clk);
		w_sys_rstn <= 1'b0;
		repeat (RESET_CYCLES) @(posedge w_csi_rx_clk);
		w_sys_rstn <= 1'b1;
	endtask

	// One-cycle write strobe
	task automatic dev_write(input logic [7:0] idx, input logic [7:0] cmd,
		input logic [31:0] data);
		@(posedge w_csi_rx_clk);
		dev_wr    <= 1'b1;
		dev_index <= idx;
		dev_cmd   <= cmd;
		dev_wdata <= data;
		@(posedge w_csi_rx_clk);
		dev_wr    <= 1'b0;
	endtask

	task automatic drive_random_pins();
		@(posedge w_csi_rx_clk);
		spi_ssn     <= 1'($urandom);
		spi_sck     <= 1'($urandom);
		spi_dat_out <= 4'($urandom);
		spi_dat_oe  <= 4'($urandom);
		i2c_scl     <= 1'($urandom);
		i2c_sda     <= 1'($urandom);
		i2c_sda_oe  <= 1'($urandom);
		pin_d1      <= 1'($urandom);
	endtask

	////////////////////
	// Tests
	task automatic test_reset_state();
		int err_start;
		err_start = errors;
		@(negedge w_csi_rx_clk);
		if (pwm !== 1'b0)
			report_mismatch("pwm_o", pwm, 1'b0);
		if (pin_cs !== 1'b1)
			report_mismatch("spi_cs_o", pin_cs, 1'b1);
		if (pin_dat[3:2] !== 2'b11)
			report_mismatch("pin_dat_o[3:2]", pin_dat[3:2], 2'b11);
		if (vid_fv !== 1'b0)
			report_mismatch("vid_fv_o", vid_fv, 1'b0);
		if (vid_lv !== 1'b0)
			report_mismatch("vid_lv_o", vid_lv, 1'b0);
		if (pix_rstn !== 1'b1)
			report_mismatch("pix_rstn_o", pix_rstn, 1'b1);
		end_test("reset_state", err_start);
	endtask

	task automatic test_sensor_passthrough();
		int err_start;
		int i;
		logic exp_fv;
		logic exp_lv;
		cam_bridge_pkg::pixel_t exp_data;
		logic nxt_fv;
		logic nxt_lv;
		logic nxt_de;
		cam_bridge_pkg::pixel_t nxt_data;
		err_start = errors;
		exp_fv = 1'b0;
		exp_lv = 1'b0;
		exp_data = '0;
		for (i = 0; i < SENSOR_BEATS; i++) begin
			@(posedge w_csi_rx_clk);
			nxt_fv   = 1'($urandom);
			nxt_lv   = 1'($urandom);
			nxt_de   = 1'($urandom);
			nxt_data = {$urandom, $urandom};
			sen_fv   <= nxt_fv;
			sen_lv   <= nxt_lv;
			sen_de   <= nxt_de;
			sen_data <= nxt_data;
			@(negedge w_csi_rx_clk);
			// Outputs carry the beat driven one edge earlier
			if (i > 0) begin
				if (vid_fv !== exp_fv)
					report_mismatch("vid_fv_o", vid_fv, exp_fv);
				if (vid_lv !== exp_lv)
					report_mismatch("vid_lv_o", vid_lv, exp_lv);
				if (vid_data !== exp_data)
					report_mismatch("vid_data_o", vid_data, exp_data);
			end
			exp_fv   = nxt_fv;
			exp_lv   = nxt_lv && nxt_de;
			exp_data = nxt_data;
		end
		@(posedge w_csi_rx_clk);
		sen_fv <= 1'b0;
		sen_lv <= 1'b0;
		sen_de <= 1'b0;
		end_test("sensor_passthrough", err_start);
	endtask

	task automatic test_pattern();
		int err_start;
		int beat;
		int lines;
		int starts;
		int falls;
		int pulses;
		int tail;
		logic prev_fv;
		logic prev_lv;
		logic prev_pix;
		err_start = errors;
		// Fresh frame counter so the LED toggle point is known
		apply_reset();
		dev_write(cam_bridge_pkg::CFG_DEV_INDEX, cam_bridge_pkg::CMD_SRC_SEL, 32'h1);
		beat = 0;
		lines = 0;
		starts = 0;
		falls = 0;
		pulses = 0;
		tail = 0;
		prev_fv = 1'b0;
		prev_lv = 1'b0;
		prev_pix = 1'b1;
		// Watch frames, then a few cycles more for the last reset pulse
		while (tail < 8) begin
			@(negedge w_csi_rx_clk);
			if (vid_lv && !vid_fv)
				report_error("line valid high outside frame valid");
			if (vid_fv && !prev_fv) begin
				starts++;
				lines = 0;
			end
			if (vid_lv) begin
				if (vid_data !== cam_bridge_pkg::pixel_t'(beat))
					report_mismatch("vid_data_o", vid_data, beat);
				beat++;
			end
			if (!vid_lv && prev_lv) begin
				if (beat != cam_bridge_pkg::PAT_H_ACTIVE)
					report_mismatch("beats per line", beat, cam_bridge_pkg::PAT_H_ACTIVE);
				lines++;
				beat = 0;
			end
			if (!vid_fv && prev_fv) begin
				falls++;
				if (lines != cam_bridge_pkg::PAT_V_ACTIVE)
					report_mismatch("lines per frame", lines, cam_bridge_pkg::PAT_V_ACTIVE);
				// LED is the top bit of the frame start count
				if (led !== (starts >= 8))
					report_mismatch("led_o", led, (starts >= 8));
			end
			if (!pix_rstn) begin
				if (!prev_pix)
					report_error("pix_rstn_o low for more than one cycle");
				pulses++;
			end
			if (falls >= PAT_FRAMES)
				tail++;
			prev_fv = vid_fv;
			prev_lv = vid_lv;
			prev_pix = pix_rstn;
		end
		if (pulses != falls)
			report_mismatch("pix_rstn_o pulse count", pulses, falls);
		end_test("pattern", err_start);
	endtask

	// High cycles over one full counter period
	task automatic check_pwm_count(input logic [7:0] duty);
		int high_cnt;
		int i;
		high_cnt = 0;
		for (i = 0; i < PWM_PERIOD; i++) begin
			@(negedge w_csi_rx_clk);
			if (pwm === 1'b1)
				high_cnt++;
		end
		if (high_cnt != int'(duty) * PWM_STEP)
			report_mismatch("pwm_o high count", high_cnt, int'(duty) * PWM_STEP);
	endtask

	task automatic test_pwm();
		int err_start;
		int k;
		logic [7:0] duties [4];
		logic [7:0] last;
		err_start = errors;
		duties[0] = 8'h00;
		duties[1] = 8'hff;
		duties[2] = 8'($urandom);
		duties[3] = 8'($urandom);
		for (k = 0; k < 4; k++) begin
			dev_write(cam_bridge_pkg::CFG_DEV_INDEX, cam_bridge_pkg::CMD_PWM_DUTY,
				{24'h0, duties[k]});
			repeat (3) @(posedge w_csi_rx_clk);
			check_pwm_count(duties[k]);
		end
		last = duties[3];
		// Wrong index, then command code 2 which is unused
		dev_write(8'h05, cam_bridge_pkg::CMD_PWM_DUTY, {24'h0, ~last});
		dev_write(cam_bridge_pkg::CFG_DEV_INDEX, 8'h02, {24'h0, ~last});
		repeat (3) @(posedge w_csi_rx_clk);
		check_pwm_count(last);
		end_test("pwm", err_start);
	endtask

	task automatic test_pin_share();
		int err_start;
		int i;
		err_start = errors;
		dev_write(cam_bridge_pkg::CFG_DEV_INDEX, cam_bridge_pkg::CMD_FLASH_EN, 32'h1);
		for (i = 0; i < PIN_BEATS; i++) begin
			drive_random_pins();
			@(negedge w_csi_rx_clk);
			if (pin_cs !== spi_ssn)
				report_mismatch("spi_cs_o", pin_cs, spi_ssn);
			if (pin_sck !== spi_sck)
				report_mismatch("spi_sck_o", pin_sck, spi_sck);
			if (pin_sck_oe !== 1'b1)
				report_mismatch("spi_sck_oe_o", pin_sck_oe, 1'b1);
			if (pin_dat !== spi_dat_out)
				report_mismatch("pin_dat_o", pin_dat, spi_dat_out);
			if (pin_dat_oe !== spi_dat_oe)
				report_mismatch("pin_dat_oe_o", pin_dat_oe, spi_dat_oe);
		end
		// Back to the sensor I2C bus
		dev_write(cam_bridge_pkg::CFG_DEV_INDEX, cam_bridge_pkg::CMD_FLASH_EN, 32'h0);
		for (i = 0; i < PIN_BEATS; i++) begin
			drive_random_pins();
			@(negedge w_csi_rx_clk);
			if (pin_cs !== 1'b1)
				report_mismatch("spi_cs_o", pin_cs, 1'b1);
			if (pin_sck !== 1'b0 || pin_sck_oe !== 1'b0)
				report_mismatch("spi_sck_o/oe", {pin_sck, pin_sck_oe}, 2'b00);
			if (pin_dat !== {2'b11, i2c_sda, i2c_scl})
				report_mismatch("pin_dat_o", pin_dat, {2'b11, i2c_sda, i2c_scl});
			if (pin_dat_oe !== {2'b11, i2c_sda_oe, 1'b1})
				report_mismatch("pin_dat_oe_o", pin_dat_oe, {2'b11, i2c_sda_oe, 1'b1});
			if (i2c_sda_in !== pin_d1)
				report_mismatch("i2c_sda_in_o", i2c_sda_in, pin_d1);
		end
		end_test("pin_share", err_start);
	endtask

	////////////////////
	// Main sequence
	initial begin
		void'($urandom(32'h2da09128));
		errors = 0;
		tests_run = 0;
		w_sys_rstn = 1'b0;
		dev_wr = 1'b0;
		dev_index = '0;
		dev_cmd = '0;
		dev_wdata = '0;
		sen_fv = 1'b0;
		sen_lv = 1'b0;
		sen_de = 1'b0;
		sen_data = '0;
		spi_ssn = 1'b1;
		spi_sck = 1'b0;
		spi_dat_out = '0;
		spi_dat_oe = '0;
		i2c_scl = 1'b1;
		i2c_sda = 1'b1;
		i2c_sda_oe = 1'b0;
		pin_d1 = 1'b1;
		repeat (RESET_CYCLES) @(posedge w_csi_rx_clk);
		w_sys_rstn <= 1'b1;

		test_reset_state();
		test_sensor_passthrough();
		test_pattern();
		test_pwm();
		test_pin_share();

		$display("tests run %0d, errors %0d", tests_run, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/backlight_pwm.sv
`timescale 1ns/100ps
`default_nettype none

module backlight_pwm (
	input  wire logic                                    w_csi_rx_clk_i,
	input  wire logic                                    w_sys_rstn_i,
	input  wire logic [cam_bridge_pkg::PWM_DUTY_W-1:0]   duty_i,
	output logic                                         pwm_o
);

	////////////////////
	// Period counter
	logic [cam_bridge_pkg::PWM_CNT_W-1:0] pwm_cnt;
	logic [cam_bridge_pkg::PWM_CNT_W-1:0] duty_ext;

	// Duty scaled to the counter, low nibble zero
	assign duty_ext = {duty_i, {(cam_bridge_pkg::PWM_CNT_W - cam_bridge_pkg::PWM_DUTY_W){1'b0}}};

	always_ff @(posedge w_csi_rx_clk_i or negedge w_sys_rstn_i) begin
		if (!w_sys_rstn_i) begin
			pwm_cnt <= '0;
			pwm_o   <= 1'b0;
		end else begin
			// Free running, 4096 cycle period
			pwm_cnt <= pwm_cnt + 1'b1;
			// High for duty*16 counts of each period
			pwm_o   <= (duty_ext > pwm_cnt);
		end
	end

	// Zero duty means backlight off
	a_duty0_dark: assert property (
		@(posedge w_csi_rx_clk_i) disable iff (!w_sys_rstn_i)
		$past(duty_i) == '0 |-> !pwm_o
	);

endmodule

`default_nettype wire

// File: hdl/cam_bridge_pkg.sv
`default_nettype none

package cam_bridge_pkg;

	////////////////////
	// Device command bus
	localparam int DEV_IDX_W  = 8;
	localparam int DEV_CMD_W  = 8;
	localparam int DEV_DATA_W = 32;

	// Index owned by the config block
	localparam logic [DEV_IDX_W-1:0] CFG_DEV_INDEX = 8'h00;

	// Commands under CFG_DEV_INDEX, code 2 unused
	typedef enum logic [DEV_CMD_W-1:0] {
		CMD_FLASH_EN = 8'h00,
		CMD_SRC_SEL  = 8'h01,
		CMD_PWM_DUTY = 8'h03
	} dev_cmd_e;

	////////////////////
	// Video path
	typedef enum logic {
		SRC_SENSOR  = 1'b0,
		SRC_PATTERN = 1'b1
	} vid_src_e;

	// 8 RAW8 pixels per beat
	localparam int PIX_W = 64;
	typedef logic [PIX_W-1:0] pixel_t;

	// Test pattern geometry, in beats and lines
	localparam int PAT_H_ACTIVE = 16;
	localparam int PAT_H_TOTAL  = 24;
	localparam int PAT_V_ACTIVE = 4;
	localparam int PAT_V_TOTAL  = 6;

	////////////////////
	// Backlight and LED
	localparam int PWM_DUTY_W  = 8;
	localparam int PWM_CNT_W   = 12;
	localparam int FRAME_CNT_W = 4;

endpackage

`default_nettype wire

// File: hdl/cam_bridge_top.sv
`timescale 1ns/100ps
`default_nettype none

module cam_bridge_top (
	input  wire logic                                    w_csi_rx_clk_i,
	input  wire logic                                    w_sys_rstn_i,

	// Device command bus
	input  wire logic                                    dev_wr_i,
	input  wire logic [cam_bridge_pkg::DEV_IDX_W-1:0]    dev_index_i,
	input  wire logic [cam_bridge_pkg::DEV_CMD_W-1:0]    dev_cmd_i,
	input  wire logic [cam_bridge_pkg::DEV_DATA_W-1:0]   dev_wdata_i,

	// Sensor pixel stream
	input  wire logic                                    sen_fv_i,
	input  wire logic                                    sen_lv_i,
	input  wire logic                                    sen_de_i,
	input  wire cam_bridge_pkg::pixel_t                  sen_data_i,

	// Flash SPI and sensor I2C masters
	input  wire logic                                    spi_ssn_i,
	input  wire logic                                    spi_sck_i,
	input  wire logic [3:0]                              spi_dat_o_i,
	input  wire logic [3:0]                              spi_dat_oe_i,
	input  wire logic                                    i2c_scl_i,
	input  wire logic                                    i2c_sda_i,
	input  wire logic                                    i2c_sda_oe_i,
	input  wire logic                                    pin_d1_i,

	output wire logic                                    vid_fv_o,
	output wire logic                                    vid_lv_o,
	output wire cam_bridge_pkg::pixel_t                  vid_data_o,
	output wire logic                                    pix_rstn_o,
	output wire logic                                    led_o,
	output wire logic                                    pwm_o,
	output wire logic                                    spi_cs_o,
	output wire logic                                    spi_sck_o,
	output wire logic                                    spi_sck_oe_o,
	output wire logic [3:0]                              pin_dat_o,
	output wire logic [3:0]                              pin_dat_oe_o,
	output wire logic                                    i2c_sda_in_o
);

	////////////////////
	// Settings from the register block
	wire logic                                   flash_en;
	wire cam_bridge_pkg::vid_src_e               src_sel;
	wire logic [cam_bridge_pkg::PWM_DUTY_W-1:0]  pwm_duty;

	cfg_regs u_cfg_regs (
		.w_csi_rx_clk_i (w_csi_rx_clk_i),
		.w_sys_rstn_i   (w_sys_rstn_i),
		.dev_wr_i       (dev_wr_i),
		.dev_index_i    (dev_index_i),
		.dev_cmd_i      (dev_cmd_i),
		.dev_wdata_i    (dev_wdata_i),
		.flash_en_o     (flash_en),
		.src_sel_o      (src_sel),
		.pwm_duty_o     (pwm_duty)
	);

	////////////////////
	// Video source and frame monitor
	video_source u_video_source (
		.w_csi_rx_clk_i (w_csi_rx_clk_i),
		.w_sys_rstn_i   (w_sys_rstn_i),
		.src_sel_i      (src_sel),
		.sen_fv_i       (sen_fv_i),
		.sen_lv_i       (sen_lv_i),
		.sen_de_i       (sen_de_i),
		.sen_data_i     (sen_data_i),
		.vid_fv_o       (vid_fv_o),
		.vid_lv_o       (vid_lv_o),
		.vid_data_o     (vid_data_o)
	);

	// Watches the selected stream, not the raw sensor
	frame_monitor u_frame_monitor (
		.w_csi_rx_clk_i (w_csi_rx_clk_i),
		.w_sys_rstn_i   (w_sys_rstn_i),
		.vid_fv_i       (vid_fv_o),
		.led_o          (led_o),
		.pix_rstn_o     (pix_rstn_o)
	);

	////////////////////
	// Backlight and pin sharing
	backlight_pwm u_backlight_pwm (
		.w_csi_rx_clk_i (w_csi_rx_clk_i),
		.w_sys_rstn_i   (w_sys_rstn_i),
		.duty_i         (pwm_duty),
		.pwm_o          (pwm_o)
	);

	flash_pin_share u_flash_pin_share (
		.flash_en_i     (flash_en),
		.spi_ssn_i      (spi_ssn_i),
		.spi_sck_i      (spi_sck_i),
		.spi_dat_o_i    (spi_dat_o_i),
		.spi_dat_oe_i   (spi_dat_oe_i),
		.i2c_scl_i      (i2c_scl_i),
		.i2c_sda_i      (i2c_sda_i),
		.i2c_sda_oe_i   (i2c_sda_oe_i),
		.pin_d1_i       (pin_d1_i),
		.spi_cs_o       (spi_cs_o),
		.spi_sck_o      (spi_sck_o),
		.spi_sck_oe_o   (spi_sck_oe_o),
		.pin_dat_o      (pin_dat_o),
		.pin_dat_oe_o   (pin_dat_oe_o),
		.i2c_sda_in_o   (i2c_sda_in_o)
	);

endmodule

`default_nettype wire

// File: hdl/cfg_regs.sv
`timescale 1ns/100ps
`default_nettype none

module cfg_regs (
	input  wire logic                                    w_csi_rx_clk_i,
	input  wire logic                                    w_sys_rstn_i,

	// Write strobe with index, command and data
	input  wire logic                                    dev_wr_i,
	input  wire logic [cam_bridge_pkg::DEV_IDX_W-1:0]    dev_index_i,
	input  wire logic [cam_bridge_pkg::DEV_CMD_W-1:0]    dev_cmd_i,
	input  wire logic [cam_bridge_pkg::DEV_DATA_W-1:0]   dev_wdata_i,

	output logic                                         flash_en_o,
	output cam_bridge_pkg::vid_src_e                     src_sel_o,
	output logic [cam_bridge_pkg::PWM_DUTY_W-1:0]        pwm_duty_o
);

	////////////////////
	// Address match
	logic wr_hit;

	// Other device indices belong to other blocks on the bus
	assign wr_hit = dev_wr_i && (dev_index_i == cam_bridge_pkg::CFG_DEV_INDEX);

	////////////////////
	// Setting registers
	always_ff @(posedge w_csi_rx_clk_i or negedge w_sys_rstn_i) begin
		if (!w_sys_rstn_i) begin
			// Flash off, sensor stream, backlight dark
			flash_en_o <= 1'b0;
			src_sel_o  <= cam_bridge_pkg::SRC_SENSOR;
			pwm_duty_o <= '0;
		end else if (wr_hit) begin
			case (dev_cmd_i)
				// Bit 0 hands the config pins to the SPI master
				cam_bridge_pkg::CMD_FLASH_EN: begin
					flash_en_o <= dev_wdata_i[0];
				end
				// Bit 0 picks the video source
				cam_bridge_pkg::CMD_SRC_SEL: begin
					src_sel_o <= cam_bridge_pkg::vid_src_e'(dev_wdata_i[0]);
				end
				// Low byte is the backlight duty
				cam_bridge_pkg::CMD_PWM_DUTY: begin
					pwm_duty_o <= dev_wdata_i[cam_bridge_pkg::PWM_DUTY_W-1:0];
				end
				// Unknown command, write dropped
				default: begin
					flash_en_o <= flash_en_o;
				end
			endcase
		end
	end

	////////////////////
	// Checks

	// Strobe must be clean once out of reset
	a_wr_known: assert property (
		@(posedge w_csi_rx_clk_i) disable iff (!w_sys_rstn_i)
		!$isunknown(dev_wr_i)
	);

endmodule

`default_nettype wire

// File: hdl/flash_pin_share.sv
`timescale 1ns/100ps
`default_nettype none

module flash_pin_share (
	input  wire logic        flash_en_i,

	// SPI master side
	input  wire logic        spi_ssn_i,
	input  wire logic        spi_sck_i,
	input  wire logic [3:0]  spi_dat_o_i,
	input  wire logic [3:0]  spi_dat_oe_i,

	// Sensor I2C master side
	input  wire logic        i2c_scl_i,
	input  wire logic        i2c_sda_i,
	input  wire logic        i2c_sda_oe_i,

	// Data line 1 pad input
	input  wire logic        pin_d1_i,

	output logic             spi_cs_o,
	output logic             spi_sck_o,
	output logic             spi_sck_oe_o,
	output logic [3:0]       pin_dat_o,
	output logic [3:0]       pin_dat_oe_o,
	output logic             i2c_sda_in_o
);

	////////////////////
	// Pin mux
	always_comb begin
		if (flash_en_i) begin
			// SPI master owns every pin
			spi_cs_o     = spi_ssn_i;
			spi_sck_o    = spi_sck_i;
			spi_sck_oe_o = 1'b1;
			pin_dat_o    = spi_dat_o_i;
			pin_dat_oe_o = spi_dat_oe_i;
			// I2C master sees an idle bus
			i2c_sda_in_o = 1'b1;
		end else begin
			// Flash deselected
			spi_cs_o     = 1'b1;
			// No second I2C bus on the clock pin
			spi_sck_o    = 1'b0;
			spi_sck_oe_o = 1'b0;
			// D3 HOLDn, D2 WPn held high, D1 SDA, D0 SCL
			pin_dat_o    = {1'b1, 1'b1, i2c_sda_i, i2c_scl_i};
			pin_dat_oe_o = {1'b1, 1'b1, i2c_sda_oe_i, 1'b1};
			i2c_sda_in_o = pin_d1_i;
		end
	end

endmodule

`default_nettype wire

// File: hdl/frame_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module frame_monitor (
	input  wire logic  w_csi_rx_clk_i,
	input  wire logic  w_sys_rstn_i,
	input  wire logic  vid_fv_i,
	output logic       led_o,
	output logic       pix_rstn_o
);

	////////////////////
	// Frame valid history
	logic [1:0] fv_hist;
	logic       fv_rise;
	logic       fv_fall;
	logic [cam_bridge_pkg::FRAME_CNT_W-1:0] frame_cnt;

	// Older sample in bit 1
	assign fv_rise = (fv_hist == 2'b01);
	assign fv_fall = (fv_hist == 2'b10);

	always_ff @(posedge w_csi_rx_clk_i or negedge w_sys_rstn_i) begin
		if (!w_sys_rstn_i) begin
			fv_hist    <= 2'b00;
			frame_cnt  <= '0;
			pix_rstn_o <= 1'b1;
		end else begin
			fv_hist <= {fv_hist[0], vid_fv_i};
			// Frame starts, wraps freely
			if (fv_rise)
				frame_cnt <= frame_cnt + 1'b1;
			// One-cycle pixel path reset at frame end
			pix_rstn_o <= !fv_fall;
		end
	end

	// LED toggles every 2^(W-1) frames
	assign led_o = frame_cnt[cam_bridge_pkg::FRAME_CNT_W-1];

	////////////////////
	// Checks

	// Reset pulse is a single cycle
	a_pix_rst_single: assert property (
		@(posedge w_csi_rx_clk_i) disable iff (!w_sys_rstn_i)
		!pix_rstn_o |=> pix_rstn_o
	);

endmodule

`default_nettype wire

// File: hdl/video_source.sv
`timescale 1ns/100ps
`default_nettype none

module video_source (
	input  wire logic                       w_csi_rx_clk_i,
	input  wire logic                       w_sys_rstn_i,
	input  wire cam_bridge_pkg::vid_src_e   src_sel_i,

	// Sensor stream, data enable qualifies line valid
	input  wire logic                       sen_fv_i,
	input  wire logic                       sen_lv_i,
	input  wire logic                       sen_de_i,
	input  wire cam_bridge_pkg::pixel_t     sen_data_i,

	output logic                            vid_fv_o,
	output logic                            vid_lv_o,
	output cam_bridge_pkg::pixel_t          vid_data_o
);

	////////////////////
	// Pattern counters
	logic [$clog2(cam_bridge_pkg::PAT_H_TOTAL)-1:0]  h_cnt;
	logic [$clog2(cam_bridge_pkg::PAT_V_TOTAL)-1:0]  v_cnt;
	logic [$clog2(cam_bridge_pkg::PAT_H_ACTIVE)-1:0] beat_cnt;
	logic pat_on;
	logic pat_fv;
	logic pat_lv;

	assign pat_on = (src_sel_i == cam_bridge_pkg::SRC_PATTERN);

	// Line 0 is vsync, last line is vertical blank
	assign pat_fv = (v_cnt >= 1) && (v_cnt <= cam_bridge_pkg::PAT_V_ACTIVE);
	assign pat_lv = pat_fv && (h_cnt < cam_bridge_pkg::PAT_H_ACTIVE);

	always_ff @(posedge w_csi_rx_clk_i or negedge w_sys_rstn_i) begin
		if (!w_sys_rstn_i) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (!pat_on) begin
			// Parked at line 0 so a switch starts a fresh frame
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == cam_bridge_pkg::PAT_H_TOTAL - 1) begin
			h_cnt <= '0;
			if (v_cnt == cam_bridge_pkg::PAT_V_TOTAL - 1)
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// Beat index within the line, cleared in blanking
	always_ff @(posedge w_csi_rx_clk_i or negedge w_sys_rstn_i) begin
		if (!w_sys_rstn_i)
			beat_cnt <= '0;
		else if (pat_on && pat_lv)
			beat_cnt <= beat_cnt + 1'b1;
		else
			beat_cnt <= '0;
	end

	////////////////////
	// Output select, one register stage for both sources
	always_ff @(posedge w_csi_rx_clk_i or negedge w_sys_rstn_i) begin
		if (!w_sys_rstn_i) begin
			vid_fv_o <= 1'b0;
			vid_lv_o <= 1'b0;
		end else if (pat_on) begin
			vid_fv_o <= pat_fv;
			vid_lv_o <= pat_lv;
		end else begin
			vid_fv_o <= sen_fv_i;
			vid_lv_o <= sen_lv_i && sen_de_i;
		end
	end

	// Pixel payload
	always_ff @(posedge w_csi_rx_clk_i) begin
		if (pat_on)
			vid_data_o <= cam_bridge_pkg::pixel_t'(beat_cnt);
		else
			vid_data_o <= sen_data_i;
	end

	// Pattern lines only ever sit inside the frame
	a_pat_lv_in_fv: assert property (
		@(posedge w_csi_rx_clk_i) disable iff (!w_sys_rstn_i)
		vid_lv_o && $past(pat_on) |-> vid_fv_o
	);

endmodule

`default_nettype wire

// File: verilog.f
hdl/cam_bridge_pkg.sv
hdl/cfg_regs.sv
hdl/video_source.sv
hdl/frame_monitor.sv
hdl/backlight_pwm.sv
hdl/flash_pin_share.sv
hdl/cam_bridge_top.sv
dv/tb_top.sv
